// File: rv_slice.f
design/rv_slice_pkg.sv
design/rv_alu.sv
design/rv_op_decode.sv
design/rv_regfile.sv
design/rv_scratch_ram.sv
design/rv_exec_ctrl.sv
design/rv_slice_top.sv
bench/rv_slice_chk.sv
bench/rv_slice_tb.sv

// File: Bender.yml
package:
  name: rv_slice

sources:
  - files:
      - design/rv_slice_pkg.sv
      - design/rv_alu.sv
      - design/rv_op_decode.sv
      - design/rv_regfile.sv
      - design/rv_scratch_ram.sv
      - design/rv_exec_ctrl.sv
      - design/rv_slice_top.sv
  - target: simulation
    files:
      - bench/rv_slice_chk.sv
      - bench/rv_slice_tb.sv

// File: bench/rv_slice_trace.txt
# columns: test name, command, arg1, arg2 (numbers in hex)
# I issues arg1 as an instruction; R reads address arg1 expecting arg2; W idles arg1 cycles
addi_x1     I 00500093 0
addi_x1     R 01 00000005
addi_x2     I ffd00113 0
addi_x2     R 02 fffffffd
slti        I 00112193 0
slti        R 03 00000001
sltiu       I 00113213 0
sltiu       R 04 00000000
xori        I 0f00c293 0
xori        R 05 000000f5
ori         I 7000e313 0
ori         R 06 00000705
andi        I 0ff17393 0
andi        R 07 000000fd
slli        I 00409413 0
slli        R 08 00000050
srli        I 01c15493 0
srli        R 09 0000000f
srai        I 40115513 0
srai        R 0a fffffffe
add         I 002085b3 0
add         R 0b 00000002
sub         I 40208633 0
sub         R 0c 00000008
sll         I 008096b3 0
sll         R 0d 00050000
slt         I 00112733 0
slt         R 0e 00000001
sltu        I 001137b3 0
sltu        R 0f 00000000
xor         I 0020c833 0
xor         R 10 fffffff8
srl         I 001158b3 0
srl         R 11 07ffffff
sra         I 40115933 0
sra         R 12 ffffffff
or          I 0020e9b3 0
or          R 13 fffffffd
and         I 0020fa33 0
and         R 14 00000005
lui         I abcdeab7 0
lui         R 15 abcde000
auipc       I 00001b17 0
auipc       R 16 00001054
x0_write    I 00708013 0
x0_write    R 00 00000000
sw_low      I 01502823 0
sw_high     I 01042223 0
settle      W 2 0
lw_low      I 01002b83 0
lw_high     I 00442c03 0
lw_low      R 17 abcde000
lw_high     R 18 fffffff8
pc_seq      R 40 0000006c
jal         I 01000cef 0
jal_pc      R 40 0000007c
jal_link    R 19 00000070
jalr        I 03140d67 0
jalr_pc     R 40 00000080
jalr_link   R 1a 00000080
beq_taken   I 01408463 0
beq_taken   R 40 00000088
beq_not     I 00208463 0
beq_not     R 40 0000008c
bne_taken   I fe209ce3 0
bne_taken   R 40 00000084
bne_not     I 01409463 0
bne_not     R 40 00000088
blt_taken   I 00114463 0
blt_taken   R 40 00000090
blt_not     I 0020c463 0
blt_not     R 40 00000094
bge_taken   I fe20dce3 0
bge_taken   R 40 0000008c
bge_not     I 00115463 0
bge_not     R 40 00000090
bltu_taken  I 0020e463 0
bltu_taken  R 40 00000098
bltu_not    I 00116463 0
bltu_not    R 40 0000009c
bgeu_taken  I fe117ce3 0
bgeu_taken  R 40 00000094
bgeu_not    I 0020f463 0
bgeu_not    R 40 00000098
unmapped    R 60 00000000

// File: bench/rv_slice_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_slice_tb;
    import rv_slice_pkg::*;

    localparam int    CLK_PERIOD      = 100;
    localparam int    RESET_CYCLES    = 3;
    localparam int    CYCLES_PER_LINE = 12;
    localparam int    SWEEP_READS     = 32; // pc plus x1..x31 after reset
    localparam string TRACE_FILE      = "bench/rv_slice_trace.txt";

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    logic        wb_ack;
    logic [31:0] wb_dat_o;

    string       names [$];
    string       cmds [$];
    logic [31:0] arg1s [$];
    logic [31:0] arg2s [$];

    int cycle_count;
    int cycle_limit;

    rv_slice_top rv_slice_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_ack   (wb_ack),
        .wb_dat_o (wb_dat_o)
    );

    bind rv_slice_top rv_slice_chk rv_slice_chk_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_ack (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("=== FAIL ===");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT never acked", cycle_count);
            abort_run("run stopped on timeout");
        end else if (rv_slice_top_inst.rv_slice_chk_inst.fail_count != 0) begin
            $display("a Wishbone protocol assertion failed");
            abort_run("protocol violation");
        end
    end

    task automatic check_eq(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", test, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic random_gap();
        idle_cycles($urandom % 4);
    endtask

    // one classic cycle; stb held until ack is seen at a falling edge
    task automatic wb_transfer(input logic we, input logic [6:0] adr,
                               input logic [31:0] dat, output logic [31:0] rdata);
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_o;
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       cmd;
        logic [31:0] a1;
        logic [31:0] a2;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            abort_run("no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %h %h", name, cmd, a1, a2);
                if (n != 4 || !(cmd == "I" || cmd == "R" || cmd == "W")) begin
                    $display("trace line could not be parsed: %s", line);
                    abort_run("bad trace");
                end
                names.push_back(name);
                cmds.push_back(cmd);
                arg1s.push_back(a1);
                arg2s.push_back(a2);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [31:0] rdata;
        wb_req      = '0;
        rst_n       = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        void'($urandom(32'h8ad9_3d36));
        load_trace();
        cycle_limit = (names.size() + SWEEP_READS) * CYCLES_PER_LINE;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        random_gap();
        wb_transfer(1'b0, ADR_ISSUE, 32'd0, rdata);
        check_eq("reset_pc", RESET_PC, rdata);
        for (int r = 1; r < 32; r++) begin
            random_gap();
            wb_transfer(1'b0, ADR_REG_BASE + 7'(r), 32'd0, rdata);
            check_eq($sformatf("reset_x%0d", r), 32'd0, rdata);
        end

        for (int i = 0; i < names.size(); i++) begin
            random_gap();
            if (cmds[i] == "I") begin
                wb_transfer(1'b1, ADR_ISSUE, arg1s[i], rdata);
            end else if (cmds[i] == "R") begin
                wb_transfer(1'b0, arg1s[i][6:0], 32'd0, rdata);
                check_eq(names[i], arg2s[i], rdata);
            end else begin
                idle_cycles(int'(arg1s[i]));
            end
        end

        if (rv_slice_top_inst.rv_slice_chk_inst.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("a Wishbone protocol assertion failed");
            abort_run("protocol violation");
        end
    end

endmodule

`default_nettype wire

// File: bench/rv_slice_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_slice_chk (
    input logic                  clk,
    input logic                  rst_n,
    input rv_slice_pkg::wb_req_t wb_req,
    input logic                  wb_ack
);

    int fail_count = 0;

    // ack only inside an active cycle
    ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_req.cyc && wb_req.stb)
    ) else begin
        $error("wb_ack seen without cyc and stb");
        fail_count++;
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack
    ) else begin
        $error("wb_ack high on two consecutive cycles");
        fail_count++;
    end

    ack_low_in_reset: assert property (
        @(posedge clk) !rst_n |-> !wb_ack
    ) else begin
        $error("wb_ack high while in reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: design/rv_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_slice_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_slice_pkg::wb_req_t wb_req,
    output logic                  wb_ack,
    output logic [31:0]           wb_dat_o
);
    import rv_slice_pkg::*;

    instr_u      instr;
    dec_ctrl_t   dec;
    alu_op_e     alu_op;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    reg_wr_t     reg_wr;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        ram_en;
    logic        ram_we;
    logic [5:0]  ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;

    rv_exec_ctrl rv_exec_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_ack     (wb_ack),
        .wb_dat_o   (wb_dat_o),
        .instr      (instr),
        .dec        (dec),
        .alu_op     (alu_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .alu_result (alu_result),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .reg_wr     (reg_wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    rv_op_decode rv_op_decode_inst (
        .instr (instr),
        .dec   (dec)
    );

    rv_alu rv_alu_inst (
        .alu_op (alu_op),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (alu_result)
    );

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .reg_wr   (reg_wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    rv_scratch_ram rv_scratch_ram_inst (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: design/rv_exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_slice_pkg::wb_req_t   wb_req,
    output logic                    wb_ack,
    output logic [31:0]             wb_dat_o,
    output rv_slice_pkg::instr_u    instr,
    input  rv_slice_pkg::dec_ctrl_t dec,
    output rv_slice_pkg::alu_op_e   alu_op,
    output logic [31:0]             op_a,
    output logic [31:0]             op_b,
    input  logic [31:0]             alu_result,
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    input  logic [31:0]             rs1_data,
    input  logic [31:0]             rs2_data,
    output rv_slice_pkg::reg_wr_t   reg_wr,
    output logic [4:0]              rd_addr,
    input  logic [31:0]             rd_data,
    output logic                    ram_en,
    output logic                    ram_we,
    output logic [5:0]              ram_addr,
    output logic [31:0]             ram_wdata,
    input  logic [31:0]             ram_rdata
);
    import rv_slice_pkg::*;

    typedef enum logic [1:0] {IDLE, EXEC, LOAD_WB, ACK} state_e;

    state_e      state;
    logic [31:0] pc;
    logic [31:0] imm;
    logic [31:0] target;
    logic [31:0] next_pc;
    logic [31:0] host_rdata;
    logic        issue;
    logic        rd_we;
    logic        cond;
    logic        taken;
    logic        exec_issue;
    opcode_e     opcode;

    assign opcode     = instr.r_fmt.opcode;
    assign issue      = wb_req.we && wb_req.adr == ADR_ISSUE; // held by host until ack
    assign exec_issue = state == EXEC && issue;

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = {instr.u_fmt.imm_31_12, 12'd0};
            OPC_JAL: imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                            instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                            instr.j_fmt.imm_10_1, 1'b0};
            OPC_BRANCH: imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                               instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                               instr.b_fmt.imm_4_1, 1'b0};
            OPC_STORE: imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                              instr.s_fmt.imm_4_0};
            default: imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
        endcase
    end

    assign alu_op   = dec.alu_op;
    assign rs1_addr = instr.r_fmt.rs1;
    assign rs2_addr = instr.r_fmt.rs2;

    always_comb begin
        case (dec.src_sel)
            SRC_RS1_RS2:  begin op_a = rs1_data; op_b = rs2_data; end
            SRC_PC_IMM:   begin op_a = pc;       op_b = imm;      end
            SRC_PC_4:     begin op_a = pc;       op_b = 32'd4;    end
            SRC_ZERO_IMM: begin op_a = 32'd0;    op_b = imm;      end
            default:      begin op_a = rs1_data; op_b = imm;      end
        endcase
    end

    // sub result tested for zero, slt/sltu use bit 0; odd funct3 inverts
    assign cond   = (dec.alu_op == ALU_SUB) ? (alu_result == 32'd0) : alu_result[0];
    assign taken  = opcode == OPC_BRANCH && dec.alu_op != ALU_NONE
                    && (cond ^ instr.b_fmt.funct3[0]);
    assign target = ((opcode == OPC_JALR) ? rs1_data : pc) + imm; // shared jump adder

    always_comb begin
        if (opcode == OPC_JALR) begin
            next_pc = {target[31:1], 1'b0};
        end else if (opcode == OPC_JAL || taken) begin
            next_pc = target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP:
                rd_we = dec.alu_op != ALU_NONE;
            default: rd_we = 1'b0;
        endcase
    end

    always_comb begin
        reg_wr.addr = instr.r_fmt.rd;
        if (state == LOAD_WB) begin
            reg_wr.en   = 1'b1;
            reg_wr.data = ram_rdata;
        end else begin
            reg_wr.en   = exec_issue && rd_we;
            reg_wr.data = alu_result;
        end
    end

    assign ram_en    = exec_issue && dec.mem_op != MEM_NONE;
    assign ram_we    = dec.mem_op == MEM_STORE;
    assign ram_addr  = alu_result[7:2]; // word index
    assign ram_wdata = rs2_data;

    assign rd_addr = wb_req.adr[4:0];

    always_comb begin
        if (wb_req.adr[6:5] == ADR_REG_BASE[6:5]) begin
            host_rdata = rd_data;
        end else if (wb_req.adr == ADR_ISSUE) begin
            host_rdata = pc;
        end else begin
            host_rdata = 32'd0; // unmapped
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && wb_req.cyc && wb_req.stb && issue) begin
            instr <= wb_req.dat;
        end
        if (state == EXEC) begin
            wb_dat_o <= wb_req.we ? 32'd0 : host_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            wb_ack <= 1'b0;
            pc     <= RESET_PC;
        end else begin
            case (state)
                IDLE: begin
                    if (wb_req.cyc && wb_req.stb) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (issue) begin
                        pc <= next_pc;
                    end
                    if (issue && dec.mem_op == MEM_LOAD) begin
                        state <= LOAD_WB; // wait for ram data
                    end else begin
                        wb_ack <= 1'b1;
                        state  <= ACK;
                    end
                end
                LOAD_WB: begin
                    wb_ack <= 1'b1;
                    state  <= ACK;
                end
                default: begin
                    wb_ack <= 1'b0;
                    state  <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rv_scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

module rv_scratch_ram (
    input  logic        clk,
    input  logic        ram_en,
    input  logic        ram_we,
    input  logic [5:0]  ram_addr,
    input  logic [31:0] ram_wdata,
    output logic [31:0] ram_rdata
);
    import rv_slice_pkg::*;

    logic [31:0] mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr]; // valid next cycle
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            rs1_addr,
    input  logic [4:0]            rs2_addr,
    output logic [31:0]           rs1_data,
    output logic [31:0]           rs2_data,
    input  rv_slice_pkg::reg_wr_t reg_wr,
    input  logic [4:0]            rd_addr,
    output logic [31:0]           rd_data
);
    import rv_slice_pkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (reg_wr.en && reg_wr.addr != 5'd0) begin // x0 never written
            regs[reg_wr.addr] <= reg_wr.data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign rd_data  = regs[rd_addr]; // host port

endmodule

`default_nettype wire

// File: design/rv_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_op_decode (
    input  rv_slice_pkg::instr_u    instr,
    output rv_slice_pkg::dec_ctrl_t dec
);
    import rv_slice_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    opcode_e    opcode;

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7; // imm[11:5] for shift immediates

    always_comb begin
        dec.alu_op = ALU_NONE;
        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: dec.alu_op = ALU_ADD;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000, 3'b001: dec.alu_op = ALU_SUB;  // beq, bne
                    3'b100, 3'b101: dec.alu_op = ALU_SLT;  // blt, bge
                    3'b110, 3'b111: dec.alu_op = ALU_SLTU; // bltu, bgeu
                    default:        dec.alu_op = ALU_NONE;
                endcase
            end
            OPC_LOAD, OPC_STORE: begin
                if (funct3 == 3'b010) begin // word only
                    dec.alu_op = ALU_ADD;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: dec.alu_op = ALU_ADD;
                    3'b010: dec.alu_op = ALU_SLT;
                    3'b011: dec.alu_op = ALU_SLTU;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    3'b001: dec.alu_op = (funct7 == 7'h00) ? ALU_SLL : ALU_NONE;
                    3'b101: begin
                        case (funct7)
                            7'h00:   dec.alu_op = ALU_SRL;
                            7'h20:   dec.alu_op = ALU_SRA;
                            default: dec.alu_op = ALU_NONE;
                        endcase
                    end
                    default: dec.alu_op = ALU_NONE;
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec.alu_op = ALU_SUB;
                    {7'h00, 3'b001}: dec.alu_op = ALU_SLL;
                    {7'h00, 3'b010}: dec.alu_op = ALU_SLT;
                    {7'h00, 3'b011}: dec.alu_op = ALU_SLTU;
                    {7'h00, 3'b100}: dec.alu_op = ALU_XOR;
                    {7'h00, 3'b101}: dec.alu_op = ALU_SRL;
                    {7'h20, 3'b101}: dec.alu_op = ALU_SRA;
                    {7'h00, 3'b110}: dec.alu_op = ALU_OR;
                    {7'h00, 3'b111}: dec.alu_op = ALU_AND;
                    default:         dec.alu_op = ALU_NONE;
                endcase
            end
            default: dec.alu_op = ALU_NONE; // fence, system, unknown
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_LUI:            dec.src_sel = SRC_ZERO_IMM;
            OPC_AUIPC:          dec.src_sel = SRC_PC_IMM;
            OPC_JAL, OPC_JALR:  dec.src_sel = SRC_PC_4;   // link value
            OPC_BRANCH, OPC_OP: dec.src_sel = SRC_RS1_RS2;
            default:            dec.src_sel = SRC_RS1_IMM;
        endcase
    end

    always_comb begin
        dec.mem_op = MEM_NONE;
        if (funct3 == 3'b010) begin
            if (opcode == OPC_LOAD) begin
                dec.mem_op = MEM_LOAD;
            end else if (opcode == OPC_STORE) begin
                dec.mem_op = MEM_STORE;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_slice_pkg::alu_op_e alu_op,
    input  logic [31:0]           op_a,
    input  logic [31:0]           op_b,
    output logic [31:0]           result
);
    import rv_slice_pkg::*;

    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'd0, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/rv_slice_pkg.sv
`default_nettype none

package rv_slice_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYS    = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        SRC_RS1_RS2, SRC_RS1_IMM, SRC_PC_IMM, SRC_PC_4, SRC_ZERO_IMM
    } src_sel_e;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        alu_op_e  alu_op;
        src_sel_e src_sel;
        mem_op_e  mem_op;
    } dec_ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [6:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } reg_wr_t;

    localparam logic [6:0]  ADR_REG_BASE = 7'h00; // x0..x31
    localparam logic [6:0]  ADR_ISSUE    = 7'h40; // write issues, read gives pc
    localparam logic [31:0] RESET_PC     = 32'h0000_0000;
    localparam int          RAM_WORDS    = 64;

endpackage

`default_nettype wire
